//--- all.f
design/cpu_sys_pkg.sv
design/rv_isa_pkg.sv
design/imem_bus_if.sv
design/reg_file.sv
design/alu.sv
design/control_unit.sv
design/cpu_core.sv
design/shared_imem.sv
design/cpu_system.sv
testbench/cpu_checker.sv
testbench/cpu_monitor.sv
testbench/tb_cpu_system.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cpu_system
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_cpu_system.sv
// cpu system testbench
// loads programs through the load port, runs them under the run level,
// then sweeps every register through the debug read port
`timescale 1ns/100ps

module tb_cpu_system;

    localparam int IMEM_DEPTH = cpu_sys_pkg::IMEM_DEPTH_DEFAULT;
    localparam int RUN_LIMIT  = 2000;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   run;
    logic                   load_we;
    cpu_sys_pkg::imem_idx_t load_addr;
    cpu_sys_pkg::word_t     load_data;
    cpu_sys_pkg::reg_idx_t  reg_addr;
    cpu_sys_pkg::pc_t       pc;
    logic                   retire;
    cpu_sys_pkg::word_t     reg_data;
    logic                   sweep_valid;
    int                     error_count;
    int                     retire_count;
    int                     timeouts = 0;
    integer                 seed = 32'h78f9635e;
    cpu_sys_pkg::word_t     prog [$];

    always #50 clk = ~clk;

    cpu_system #(.IMEM_DEPTH(IMEM_DEPTH)) u_dut (
        .clk(clk), .reset(reset), .run(run), .load_we(load_we), .load_addr(load_addr),
        .load_data(load_data), .reg_addr(reg_addr), .pc(pc), .retire(retire),
        .reg_data(reg_data)
    );

    cpu_monitor #(.IMEM_DEPTH(IMEM_DEPTH)) u_monitor (
        .clk(clk), .reset(reset), .run(run), .load_we(load_we), .load_addr(load_addr),
        .load_data(load_data), .reg_addr(reg_addr), .pc(pc), .retire(retire),
        .reg_data(reg_data), .sweep_valid(sweep_valid), .error_count(error_count),
        .retire_count(retire_count)
    );

    // instruction encoders
    function automatic cpu_sys_pkg::word_t r_instr(input logic [6 : 0] f7,
        input logic [2 : 0] f3, input cpu_sys_pkg::reg_idx_t rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic cpu_sys_pkg::word_t i_instr(input logic [2 : 0] f3,
        input cpu_sys_pkg::reg_idx_t rd, rs1, input int imm);
        return {imm[11 : 0], rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic cpu_sys_pkg::word_t lui_instr(input cpu_sys_pkg::reg_idx_t rd,
        input int imm);
        return {imm[19 : 0], rd, 7'b0110111};
    endfunction

    function automatic cpu_sys_pkg::word_t b_instr(input logic [2 : 0] f3,
        input cpu_sys_pkg::reg_idx_t rs1, rs2, input int off);
        return {off[12], off[10 : 5], rs2, rs1, f3, off[4 : 1], off[11], 7'b1100011};
    endfunction

    task automatic reset_dut();
        @(posedge clk);
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // idle with run low so pc sits at zero
        repeat (4) @(posedge clk);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= cpu_sys_pkg::imem_idx_t'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    // mode 1 injects loads while running and mode 2 toggles run at random
    task automatic run_program(input int mode, output bit reached);
        cpu_sys_pkg::pc_t halt_pc;
        logic [31 : 0]    rnd;
        halt_pc = 32'(4 * (prog.size() - 1));
        reached = 1'b0;
        @(posedge clk);
        run <= 1'b1;
        for (int count = 0; count < RUN_LIMIT && !reached; count++) begin
            @(posedge clk);
            rnd = $random(seed);
            load_we <= 1'b0;
            if (pc === halt_pc) begin
                reached = 1'b1;
                run <= 1'b0;
            end else if (mode == 1 && count < 12 && count % 3 == 1) begin
                load_we   <= 1'b1;
                load_addr <= cpu_sys_pkg::imem_idx_t'(240 + count);
                load_data <= rnd;
            end else if (mode == 2) begin
                run <= rnd[0];
            end
        end
        if (!reached) begin
            $display("timeout: pc never reached the halt address %h", halt_pc);
            timeouts++;
        end
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            reg_addr    <= 5'(i);
            sweep_valid <= 1'b1;
        end
        @(posedge clk);
        sweep_valid <= 1'b0;
    endtask

    task automatic build_random_program(input int length);
        logic [31 : 0] rnd;
        logic [9 : 0]  funct;
        prog.delete();
        for (int i = 0; i < length; i++) begin
            rnd = $random(seed);
            case (rnd[2 : 0])
                3'd1:    funct = {7'h20, 3'b000};
                3'd2:    funct = {7'h00, 3'b111};
                3'd3:    funct = {7'h00, 3'b110};
                3'd4:    funct = {7'h00, 3'b001};
                3'd5:    funct = {7'h00, 3'b101};
                default: funct = {7'h00, 3'b000};
            endcase
            prog.push_back(r_instr(funct[9 : 3], funct[2 : 0], rnd[7 : 3], rnd[12 : 8],
                                   rnd[17 : 13]));
        end
        prog.push_back(b_instr(3'b000, 0, 0, 0));
    endtask

    task automatic run_tests();
        bit reached;
        // straight line program with every register written first
        prog.delete();
        for (int i = 1; i < 32; i++) begin
            prog.push_back(i_instr(3'b000, 5'(i), 0, i * 37 - 500));
        end
        prog.push_back(i_instr(3'b110, 5, 3, 'h0f0));
        prog.push_back(lui_instr(6, 'habcde));
        prog.push_back(r_instr(7'h00, 3'b000, 7, 1, 2));
        prog.push_back(r_instr(7'h20, 3'b000, 8, 3, 31));
        prog.push_back(r_instr(7'h00, 3'b111, 9, 6, 30));
        prog.push_back(r_instr(7'h00, 3'b110, 10, 6, 29));
        prog.push_back(r_instr(7'h00, 3'b001, 11, 30, 2));
        prog.push_back(r_instr(7'h00, 3'b101, 12, 6, 4));
        prog.push_back(i_instr(3'b001, 13, 6, 7));
        prog.push_back(i_instr(3'b000, 14, 6, -1));
        prog.push_back(r_instr(7'h00, 3'b000, 0, 1, 2));
        prog.push_back(b_instr(3'b000, 0, 0, 0));
        load_program();
        reset_dut();
        run_program(0, reached);
        if (!reached) return;
        sweep_regs();

        // branches with a backward loop and loads injected while running
        prog.delete();
        prog.push_back(i_instr(3'b000, 1, 0, 0));
        prog.push_back(i_instr(3'b000, 2, 0, 5));
        prog.push_back(i_instr(3'b000, 1, 1, 1));
        prog.push_back(b_instr(3'b001, 1, 2, -4));
        prog.push_back(b_instr(3'b000, 1, 2, 8));
        prog.push_back(i_instr(3'b000, 3, 0, 99));
        prog.push_back(b_instr(3'b000, 1, 0, 8));
        prog.push_back(b_instr(3'b001, 1, 2, 8));
        prog.push_back(b_instr(3'b001, 1, 0, 8));
        prog.push_back(i_instr(3'b000, 3, 0, 77));
        prog.push_back(i_instr(3'b000, 4, 0, 11));
        prog.push_back(b_instr(3'b000, 0, 0, 0));
        load_program();
        reset_dut();
        run_program(1, reached);
        if (!reached) return;
        sweep_regs();

        // random register-register ops with run toggling
        build_random_program(24);
        load_program();
        reset_dut();
        run_program(2, reached);
        if (!reached) return;
        sweep_regs();
    endtask

    initial begin
        int total;
        reset       = 1'b1;
        run         = 1'b0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        reg_addr    = '0;
        sweep_valid = 1'b0;
        run_tests();
        repeat (2) @(posedge clk);
        total = error_count + timeouts + u_dut.u_checker.fail_count;
        $display("errors: %0d compare, %0d timeout, %0d assertion, %0d retired",
                 error_count, timeouts, u_dut.u_checker.fail_count, retire_count);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_cpu_system

//--- testbench/cpu_monitor.sv
// cpu system reference model and scoreboard
// mirrors the program memory from the load port, steps a model core
// on every expected retirement and compares pc, retire and swept registers
`timescale 1ns/100ps

module cpu_monitor #(
    parameter int IMEM_DEPTH = 256
) (
    input   logic                   clk,
    input   logic                   reset,
    input   logic                   run,
    input   logic                   load_we,
    input   cpu_sys_pkg::imem_idx_t load_addr,
    input   cpu_sys_pkg::word_t     load_data,
    input   cpu_sys_pkg::reg_idx_t  reg_addr,
    input   cpu_sys_pkg::pc_t       pc,
    input   logic                   retire,
    input   cpu_sys_pkg::word_t     reg_data,
    input   logic                   sweep_valid,
    output  int                     error_count,
    output  int                     retire_count
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    cpu_sys_pkg::word_t prog [IMEM_DEPTH];
    cpu_sys_pkg::word_t model_regs [32];
    cpu_sys_pkg::pc_t   model_pc = '0;
    int                 errors = 0;
    int                 retired = 0;

    assign error_count  = errors;
    assign retire_count = retired;

    initial begin
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
    end

    // words past the end of the array read as zero
    function automatic cpu_sys_pkg::word_t fetch_word(input cpu_sys_pkg::pc_t addr);
        if ((addr >> 2) < 32'(IMEM_DEPTH)) begin
            return prog[addr[IDX_W + 1 : 2]];
        end
        return '0;
    endfunction

    // one instruction of the reference model
    function automatic void step_model(
        input  cpu_sys_pkg::pc_t      cur_pc,
        input  cpu_sys_pkg::word_t    instr,
        output cpu_sys_pkg::pc_t      next_pc,
        output logic                  wr_en,
        output cpu_sys_pkg::reg_idx_t wr_idx,
        output cpu_sys_pkg::word_t    wr_val
    );
        cpu_sys_pkg::word_t a;
        cpu_sys_pkg::word_t b;
        cpu_sys_pkg::word_t imm_i;
        cpu_sys_pkg::word_t imm_b;
        logic [9 : 0]       funct;
        a       = model_regs[instr[19 : 15]];
        b       = model_regs[instr[24 : 20]];
        imm_i   = {{20{instr[31]}}, instr[31 : 20]};
        imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30 : 25], instr[11 : 8], 1'b0};
        funct   = {instr[31 : 25], instr[14 : 12]};
        next_pc = cur_pc + 32'd4;
        wr_en   = 1'b1;
        wr_idx  = instr[11 : 7];
        wr_val  = '0;
        case (instr[6 : 0])
            7'b0110011: begin
                case (funct)
                    {7'h00, 3'b000}: wr_val = a + b;
                    {7'h20, 3'b000}: wr_val = a - b;
                    {7'h00, 3'b111}: wr_val = a & b;
                    {7'h00, 3'b110}: wr_val = a | b;
                    {7'h00, 3'b001}: wr_val = a << b[4 : 0];
                    {7'h00, 3'b101}: wr_val = a >> b[4 : 0];
                    default:         wr_en = 1'b0;
                endcase
            end
            7'b0010011: begin
                case (instr[14 : 12])
                    3'b000:  wr_val = a + imm_i;
                    3'b110:  wr_val = a | imm_i;
                    3'b001: begin
                        wr_val = a << instr[24 : 20];
                        wr_en  = (instr[31 : 25] == 7'h00);
                    end
                    default: wr_en = 1'b0;
                endcase
            end
            7'b0110111: wr_val = {instr[31 : 12], 12'h000};
            7'b1100011: begin
                wr_en = 1'b0;
                if ((instr[14 : 12] == 3'b000 && a == b) ||
                    (instr[14 : 12] == 3'b001 && a != b)) begin
                    next_pc = cur_pc + imm_b;
                end
            end
            default: wr_en = 1'b0;
        endcase
        // x0 never changes
        if (wr_idx == '0) begin
            wr_en = 1'b0;
        end
    endfunction

    always @(posedge clk) begin : compare
        cpu_sys_pkg::pc_t      nxt_pc;
        logic                  wr_en;
        cpu_sys_pkg::reg_idx_t wr_idx;
        cpu_sys_pkg::word_t    wr_val;
        logic                  exp_retire;
        if (reset) begin
            model_pc = '0;
        end else begin
            exp_retire = run && !load_we;
            if (retire !== exp_retire) begin
                $display("error at %0t: retire %b, expected %b", $time, retire, exp_retire);
                errors++;
            end
            if (pc !== model_pc) begin
                $display("error at %0t: pc %h, expected %h", $time, pc, model_pc);
                errors++;
            end
            if (exp_retire) begin
                step_model(model_pc, fetch_word(model_pc), nxt_pc, wr_en, wr_idx, wr_val);
                if (wr_en) begin
                    model_regs[wr_idx] = wr_val;
                end
                model_pc = nxt_pc;
                retired++;
            end
            if (sweep_valid && reg_data !== model_regs[reg_addr]) begin
                $display("error at %0t: x%0d reads %h, expected %h", $time, reg_addr,
                         reg_data, model_regs[reg_addr]);
                errors++;
            end
        end
        if (load_we) begin
            prog[load_addr] = load_data;
        end
    end

endmodule : cpu_monitor

//--- testbench/cpu_checker.sv
// cpu system assertions
// bound into the top level; checks the core stays idle in reset,
// the load port always wins over fetch, and the pc stays word aligned
`timescale 1ns/100ps

module cpu_checker (
    input   logic               clk,
    input   logic               reset,
    input   logic               load_we,
    input   logic               retire,
    input   cpu_sys_pkg::pc_t   pc
);

    int fail_count = 0;

    retire_in_reset: assert property (@(posedge clk) reset |-> !retire)
        else begin
            $error("retire high while reset is applied");
            fail_count++;
        end

    // a load write withholds the grant in the same cycle
    retire_during_load: assert property (@(posedge clk) disable iff (reset)
        load_we |-> !retire)
        else begin
            $error("retire high in a cycle with a load write");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1 : 0] == 2'b00)
        else begin
            $error("pc not word aligned");
            fail_count++;
        end

endmodule : cpu_checker

bind cpu_system cpu_checker u_checker (
    .clk     ( clk     ),
    .reset   ( reset   ),
    .load_we ( load_we ),
    .retire  ( retire  ),
    .pc      ( pc      )
);

//--- design/cpu_system.sv
// cpu system top level
// joins the single-cycle core to the shared instruction memory;
// programs come in through the load port, registers are visible
// through the debug read port
`timescale 1ns/100ps

module cpu_system #(
    parameter int IMEM_DEPTH = cpu_sys_pkg::IMEM_DEPTH_DEFAULT
) (
    input   logic                   clk,
    input   logic                   reset,
    input   logic                   run,
    input   logic                   load_we,
    input   cpu_sys_pkg::imem_idx_t load_addr,
    input   cpu_sys_pkg::word_t     load_data,
    input   cpu_sys_pkg::reg_idx_t  reg_addr,
    output  cpu_sys_pkg::pc_t       pc,
    output  logic                   retire,
    output  cpu_sys_pkg::word_t     reg_data
);

    // fetch path between core and memory
    imem_bus_if imem_bus ();

    cpu_core u_core (
        .clk        ( clk       ),
        .reset      ( reset     ),
        .run        ( run       ),
        .bus        ( imem_bus  ),
        .pc         ( pc        ),
        .retire     ( retire    ),
        .reg_addr   ( reg_addr  ),
        .reg_data   ( reg_data  )
    );

    shared_imem #(
        .IMEM_DEPTH ( IMEM_DEPTH )
    ) u_imem (
        .clk        ( clk       ),
        .load_we    ( load_we   ),
        .load_addr  ( load_addr ),
        .load_data  ( load_data ),
        .bus        ( imem_bus  )
    );

endmodule : cpu_system

//--- design/shared_imem.sv
// shared instruction memory
// one program array written by the external load port and read by
// the core fetch port; a load write wins and withholds the grant
`timescale 1ns/100ps

module shared_imem #(
    parameter int IMEM_DEPTH = cpu_sys_pkg::IMEM_DEPTH_DEFAULT
) (
    input   logic                   clk,
    input   logic                   load_we,
    input   cpu_sys_pkg::imem_idx_t load_addr,
    input   cpu_sys_pkg::word_t     load_data,
    imem_bus_if.memory              bus
);

    localparam int IDX_W = (IMEM_DEPTH > 1) ? $clog2(IMEM_DEPTH) : 1;

    cpu_sys_pkg::word_t mem [IMEM_DEPTH];

    // both indices widened to 32 bits before range checks
    logic   [31 : 0]    load_word;
    logic   [31 : 0]    fetch_word;
    logic               load_in_range;
    logic               fetch_in_range;

    assign load_word      = 32'(load_addr);
    assign fetch_word     = {2'b00, bus.addr[31 : 2]};
    assign load_in_range  = load_word < 32'(IMEM_DEPTH);
    assign fetch_in_range = fetch_word < 32'(IMEM_DEPTH);

    always_ff @(posedge clk) begin
        if (load_we && load_in_range) begin
            mem[load_word[IDX_W - 1 : 0]] <= load_data;
        end
    end

    // out of range reads give all zeros, decoded as a no-op
    assign bus.instr = fetch_in_range ? mem[fetch_word[IDX_W - 1 : 0]] : '0;

    // load port has priority over the core
    assign bus.gnt = bus.req && !load_we;

endmodule : shared_imem

//--- design/cpu_core.sv
// single-cycle rv32i subset core
// holds the pc, slices and extends instruction fields, picks the
// alu operands and the next pc; retires one instruction per grant
`timescale 1ns/100ps

module cpu_core (
    input   logic                   clk,
    input   logic                   reset,
    input   logic                   run,
    imem_bus_if.core                bus,
    output  cpu_sys_pkg::pc_t       pc,
    output  logic                   retire,
    input   cpu_sys_pkg::reg_idx_t  reg_addr,
    output  cpu_sys_pkg::word_t     reg_data
);

    cpu_sys_pkg::word_t     instr;
    // decoded fields
    rv_isa_pkg::opcode_t    opcode;
    rv_isa_pkg::funct3_t    funct3;
    rv_isa_pkg::funct7_t    funct7;
    cpu_sys_pkg::reg_idx_t  rs1;
    cpu_sys_pkg::reg_idx_t  rs2;
    cpu_sys_pkg::reg_idx_t  rd;
    logic       [4 : 0]     instr_shamt;
    // control levels
    rv_isa_pkg::alu_op_e    alu_op;
    rv_isa_pkg::imm_kind_e  imm_kind;
    logic                   src_b_imm;
    logic                   reg_we;
    logic                   branch;
    logic                   branch_ne;
    logic                   shift_imm;
    // datapath
    cpu_sys_pkg::word_t     imm_ext;
    cpu_sys_pkg::word_t     rd1;
    cpu_sys_pkg::word_t     rd2;
    cpu_sys_pkg::word_t     src_b;
    cpu_sys_pkg::word_t     alu_result;
    logic       [4 : 0]     alu_shamt;
    logic                   branch_taken;
    cpu_sys_pkg::pc_t       pc_next;

    assign bus.req  = run;
    assign bus.addr = pc;
    assign instr    = bus.instr;
    assign retire   = bus.gnt;

    assign opcode      = instr[6 : 0];
    assign rd          = instr[11 : 7];
    assign funct3      = instr[14 : 12];
    assign rs1         = instr[19 : 15];
    assign rs2         = instr[24 : 20];
    assign funct7      = instr[31 : 25];
    assign instr_shamt = instr[24 : 20];

    // sign or zero extension by format
    always_comb begin
        case (imm_kind)
            rv_isa_pkg::IMM_U: imm_ext = {instr[31 : 12], 12'b0};
            rv_isa_pkg::IMM_B: imm_ext = {{20{instr[31]}}, instr[31], instr[7],
                                          instr[30 : 25], instr[11 : 8]};
            default:           imm_ext = {{20{instr[31]}}, instr[31 : 20]};
        endcase
    end

    assign src_b     = src_b_imm ? imm_ext : rd2;
    assign alu_shamt = shift_imm ? instr_shamt : rd2[4 : 0];

    // beq taken on equal, bne on not equal
    assign branch_taken = branch && ((rd1 == rd2) ^ branch_ne);
    assign pc_next      = branch_taken ? pc + (imm_ext << 1) : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (bus.gnt) begin
            pc <= pc_next;
        end
    end

    reg_file u_reg_file (
        .clk        ( clk               ),
        .ra1        ( rs1               ),
        .ra2        ( rs2               ),
        .wa         ( rd                ),
        .debug_addr ( reg_addr          ),
        .wd         ( alu_result        ),
        .we         ( reg_we && bus.gnt ),
        .rd1        ( rd1               ),
        .rd2        ( rd2               ),
        .debug_data ( reg_data          )
    );

    alu u_alu (
        .src_a      ( rd1               ),
        .src_b      ( src_b             ),
        .shamt      ( alu_shamt         ),
        .op         ( alu_op            ),
        .result     ( alu_result        )
    );

    control_unit u_ctrl (
        .opcode     ( opcode            ),
        .funct3     ( funct3            ),
        .funct7     ( funct7            ),
        .alu_op     ( alu_op            ),
        .imm_kind   ( imm_kind          ),
        .src_b_imm  ( src_b_imm         ),
        .reg_we     ( reg_we            ),
        .branch     ( branch            ),
        .branch_ne  ( branch_ne         ),
        .shift_imm  ( shift_imm         )
    );

endmodule : cpu_core

//--- design/control_unit.sv
// instruction decoder
// maps opcode, funct3 and funct7 to the alu operation, immediate format
// and datapath levels; anything unsupported writes nothing and never branches
`timescale 1ns/100ps

module control_unit (
    input   rv_isa_pkg::opcode_t    opcode,
    input   rv_isa_pkg::funct3_t    funct3,
    input   rv_isa_pkg::funct7_t    funct7,
    output  rv_isa_pkg::alu_op_e    alu_op,
    output  rv_isa_pkg::imm_kind_e  imm_kind,
    output  logic                   src_b_imm,
    output  logic                   reg_we,
    output  logic                   branch,
    output  logic                   branch_ne,
    output  logic                   shift_imm
);

    always_comb begin
        alu_op    = rv_isa_pkg::ALU_ADD;
        imm_kind  = rv_isa_pkg::IMM_I;
        src_b_imm = 1'b0;
        reg_we    = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        shift_imm = 1'b0;
        case (opcode)
            rv_isa_pkg::OP_R: begin
                // only add may carry the alternate funct7
                reg_we = (funct7 == rv_isa_pkg::F7_BASE) ||
                         (funct7 == rv_isa_pkg::F7_SUB && funct3 == rv_isa_pkg::F3_ADD);
                case (funct3)
                    rv_isa_pkg::F3_ADD: begin
                        if (funct7 == rv_isa_pkg::F7_SUB) begin
                            alu_op = rv_isa_pkg::ALU_SUB;
                        end
                    end
                    rv_isa_pkg::F3_SLL: alu_op = rv_isa_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SRL: alu_op = rv_isa_pkg::ALU_SRL;
                    rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::ALU_AND;
                    default:            reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_I: begin
                src_b_imm = 1'b1;
                reg_we    = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD: alu_op = rv_isa_pkg::ALU_ADD;
                    rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_SLL: begin
                        alu_op    = rv_isa_pkg::ALU_SLL;
                        shift_imm = 1'b1;
                        reg_we    = (funct7 == rv_isa_pkg::F7_BASE);
                    end
                    default:            reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_LUI: begin
                alu_op    = rv_isa_pkg::ALU_LUI;
                imm_kind  = rv_isa_pkg::IMM_U;
                src_b_imm = 1'b1;
                reg_we    = 1'b1;
            end
            rv_isa_pkg::OP_B: begin
                imm_kind  = rv_isa_pkg::IMM_B;
                branch    = (funct3 == rv_isa_pkg::F3_BEQ) || (funct3 == rv_isa_pkg::F3_BNE);
                branch_ne = (funct3 == rv_isa_pkg::F3_BNE);
            end
            default: begin
                reg_we = 1'b0;
            end
        endcase
    end

endmodule : control_unit

//--- design/alu.sv
// integer alu
// add, sub, and, or, logical shifts and the lui pass-through;
// shift distance comes in already selected by the decode
`timescale 1ns/100ps

module alu (
    input   cpu_sys_pkg::word_t     src_a,
    input   cpu_sys_pkg::word_t     src_b,
    input   logic       [4 : 0]     shamt,
    input   rv_isa_pkg::alu_op_e    op,
    output  cpu_sys_pkg::word_t     result
);

    always_comb begin
        case (op)
            rv_isa_pkg::ALU_ADD: begin
                result = src_a + src_b;
            end
            rv_isa_pkg::ALU_SUB: begin
                result = src_a - src_b;
            end
            rv_isa_pkg::ALU_AND: begin
                result = src_a & src_b;
            end
            rv_isa_pkg::ALU_OR: begin
                result = src_a | src_b;
            end
            rv_isa_pkg::ALU_SLL: begin
                result = src_a << shamt;
            end
            rv_isa_pkg::ALU_SRL: begin
                result = src_a >> shamt;
            end
            // upper immediate arrives already shifted into place
            rv_isa_pkg::ALU_LUI: begin
                result = src_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule : alu

//--- design/reg_file.sv
// 32 x 32 architectural register file
// two operand reads, one debug read and one write on the clock edge;
// x0 is hardwired to zero
`timescale 1ns/100ps

module reg_file (
    input   logic                   clk,
    input   cpu_sys_pkg::reg_idx_t  ra1,
    input   cpu_sys_pkg::reg_idx_t  ra2,
    input   cpu_sys_pkg::reg_idx_t  wa,
    input   cpu_sys_pkg::reg_idx_t  debug_addr,
    input   cpu_sys_pkg::word_t     wd,
    input   logic                   we,
    output  cpu_sys_pkg::word_t     rd1,
    output  cpu_sys_pkg::word_t     rd2,
    output  cpu_sys_pkg::word_t     debug_data
);

    cpu_sys_pkg::word_t regs [32];

    // read with x0 forced to zero
    function automatic cpu_sys_pkg::word_t read_reg(input cpu_sys_pkg::reg_idx_t idx);
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1        = read_reg(ra1);
    assign rd2        = read_reg(ra2);
    assign debug_data = read_reg(debug_addr);

endmodule : reg_file

//--- design/imem_bus_if.sv
// instruction fetch bus
// core presents a pc and a request, the shared memory answers with
// the instruction word and a grant for the current cycle
`timescale 1ns/100ps

interface imem_bus_if;

    cpu_sys_pkg::pc_t   addr;
    cpu_sys_pkg::word_t instr;
    logic               req;
    logic               gnt;

    modport core (
        output addr,
        output req,
        input  instr,
        input  gnt
    );

    modport memory (
        input  addr,
        input  req,
        output instr,
        output gnt
    );

endinterface : imem_bus_if

//--- design/rv_isa_pkg.sv
// rv32i subset ISA definitions
// opcode and funct field encodings for the supported instructions,
// plus the ALU operation and immediate kind enums used by the decode
package rv_isa_pkg;

    // field types as sliced from a 32-bit instruction
    typedef logic [6 : 0] opcode_t;
    typedef logic [2 : 0] funct3_t;
    typedef logic [6 : 0] funct7_t;

    // major opcodes
    localparam opcode_t OP_R   = 7'b0110011;
    localparam opcode_t OP_I   = 7'b0010011;
    localparam opcode_t OP_LUI = 7'b0110111;
    localparam opcode_t OP_B   = 7'b1100011;

    // funct3 for register and immediate arithmetic
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLL = 3'b001;
    localparam funct3_t F3_SRL = 3'b101;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // funct3 for branches
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    // funct7 with sub as the only alternate form
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_SUB  = 7'b0100000;

    typedef enum logic [2 : 0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // which immediate format the instruction carries
    typedef enum logic [1 : 0] {
        IMM_I,
        IMM_U,
        IMM_B
    } imm_kind_e;

endpackage : rv_isa_pkg

//--- design/cpu_sys_pkg.sv
// cpu system widths and types
// data words, instruction addresses, register indices and
// the word index into the shared instruction memory
package cpu_sys_pkg;

    localparam int WORD_W  = 32;
    localparam int REG_IDX_W = 5;

    // default program memory depth in words
    localparam int IMEM_DEPTH_DEFAULT = 256;
    localparam int IMEM_IDX_W = $clog2(IMEM_DEPTH_DEFAULT);

    typedef logic [WORD_W - 1 : 0]     word_t;
    // byte address with the low two bits zero when aligned
    typedef logic [WORD_W - 1 : 0]     pc_t;
    typedef logic [REG_IDX_W - 1 : 0]  reg_idx_t;
    typedef logic [IMEM_IDX_W - 1 : 0] imem_idx_t;

endpackage : cpu_sys_pkg
